// ==== logic/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // ==============================
    // Bus transfer types
    // ==============================

    // Host request, 48 bits
    typedef struct packed {
        // High for a store
        logic        write;
        // Word address, not byte address
        logic [14:0] addr;
        // Ignored on reads
        logic [31:0] wdata;
    } bus_req_t;

    // Response back to the host, 34 bits
    typedef struct packed {
        // Set for every write
        logic        wr_ack;
        // Address hit nothing in the map
        logic        dec_err;
        // Zero on writes
        logic [31:0] rdata;
    } bus_rsp_t;

    // ==============================
    // Key status word
    // ==============================

    // Same 32 bits seen two ways
    // Key port fills the fields, bus returns the raw word
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        pressed;
            logic [14:0] reserved;
            logic [7:0]  scan;
            logic [7:0]  ascii;
        } fields;
    } key_word_u;

    // ==============================
    // Address map, word addresses
    // ==============================

    // RAM runs from here up to RAM_WORDS-1
    localparam logic [14:0] RAM_BASE     = 15'h0000;
    // Single registers above the RAM window
    localparam logic [14:0] KEY_ADDR     = 15'h1000;
    localparam logic [14:0] CONSOLE_ADDR = 15'h1001;
    localparam logic [14:0] IRQ_ADDR     = 15'h1002;

    // Read data for unmapped reads
    localparam logic [31:0] DECODE_ERR_DATA = 32'hDEAD_BEEF;

endpackage

// ==== logic/bus_request_queue.sv ====
`timescale 1ns/100ps

module bus_request_queue
    import soc_bus_pkg::*;
#(
    parameter int REQ_DEPTH = 4
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    // Host side, credit based
    input  logic     req_valid,
    input  bus_req_t req,
    output logic     req_credit,
    // Decoder side, valid/ready
    output logic     dq_valid,
    input  logic     dq_ready,
    output bus_req_t dq_req
);

    // Pointer and occupancy widths
    localparam int AW = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CW = $clog2(REQ_DEPTH + 1);

    bus_req_t        mem [REQ_DEPTH];
    logic [AW-1:0]   head;
    logic [AW-1:0]   tail;
    logic [CW-1:0]   count;
    logic            push;
    logic            pop;

    // Host only sends with a credit in hand, so no full check here
    assign push = req_valid;
    assign pop  = dq_valid && dq_ready;

    // Oldest entry always on the output
    assign dq_valid = (count != '0);
    assign dq_req   = mem[head];

    // Storage, payload only
    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            mem[tail] <= req;
        end
    end

    // ==============================
    // Pointers, count, credit return
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (push) begin
                // Wrap for depths that are not a power of two
                tail <= (tail == AW'(REQ_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == AW'(REQ_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count      <= count + CW'(push) - CW'(pop);
            // One credit back per dequeue, a cycle later
            req_credit <= pop;
        end
    end

    // Host pushing into a full queue means it spent a credit it did not have
    a_no_overflow: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req_valid |-> (count < CW'(REQ_DEPTH)));

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/100ps

module bus_decoder
    import soc_bus_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    // From request queue
    input  logic                         dq_valid,
    output logic                         dq_ready,
    input  bus_req_t                     dq_req,
    // To response queue
    output logic                         rs_valid,
    input  logic                         rs_ready,
    output bus_rsp_t                     rs_rsp,
    // Scratch RAM port
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    output logic [31:0]                  ram_wdata,
    input  logic [31:0]                  ram_rdata,
    // Key port
    output logic                         key_rd,
    input  key_word_u                    key_data,
    input  logic                         irq_pending,
    // Console byte out
    output logic                         console_valid,
    output logic [7:0]                   console_byte
);

    typedef enum logic [1:0] {ST_IDLE, ST_RAM_WAIT, ST_HOLD} state_t;

    state_t      state;
    bus_rsp_t    rsp_q;
    bus_rsp_t    rsp_next;
    logic [14:0] ram_off;
    logic        sel_ram;
    logic        sel_key;
    logic        sel_con;
    logic        sel_irq;
    logic        sel_none;
    logic        accept;

    // ==============================
    // Address decode
    // ==============================
    // Offset into RAM window, below base wraps high and misses
    assign ram_off  = dq_req.addr - RAM_BASE;
    assign sel_ram  = (ram_off < RAM_WORDS);
    assign sel_key  = (dq_req.addr == KEY_ADDR);
    assign sel_con  = (dq_req.addr == CONSOLE_ADDR);
    assign sel_irq  = (dq_req.addr == IRQ_ADDR);
    assign sel_none = !(sel_ram || sel_key || sel_con || sel_irq);

    // Free when empty, or when the held item leaves this cycle
    assign dq_ready = (state == ST_IDLE) || (state == ST_HOLD && rs_ready);
    assign accept   = dq_valid && dq_ready;

    // RAM access starts in the accept cycle
    assign ram_en    = accept && sel_ram;
    assign ram_we    = dq_req.write;
    assign ram_addr  = ram_off[$clog2(RAM_WORDS)-1:0];
    assign ram_wdata = dq_req.wdata;

    // Reading the key register clears its pressed flag
    assign key_rd = accept && sel_key && !dq_req.write;

    // Response for everything except RAM read data
    always_comb begin
        rsp_next.wr_ack  = dq_req.write;
        rsp_next.dec_err = sel_none;
        rsp_next.rdata   = '0;
        if (!dq_req.write) begin
            if (sel_key) begin
                rsp_next.rdata = key_data.raw;
            end else if (sel_irq) begin
                rsp_next.rdata = {31'd0, irq_pending};
            end else if (sel_none) begin
                rsp_next.rdata = DECODE_ERR_DATA;
            end
        end
    end

    assign rs_valid = (state == ST_HOLD);
    assign rs_rsp   = rsp_q;

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= ST_IDLE;
        end else if (accept) begin
            // RAM reads need the data cycle first
            state <= (sel_ram && !dq_req.write) ? ST_RAM_WAIT : ST_HOLD;
        end else if (state == ST_RAM_WAIT) begin
            state <= ST_HOLD;
        end else if (state == ST_HOLD && rs_ready) begin
            state <= ST_IDLE;
        end
    end

    // Held response
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            rsp_q <= rsp_next;
        end else if (state == ST_RAM_WAIT) begin
            rsp_q.rdata <= ram_rdata;
        end
    end

    // Console strobe, low byte only
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            console_valid <= 1'b0;
        end else begin
            console_valid <= accept && sel_con && dq_req.write;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (accept && sel_con && dq_req.write) begin
            console_byte <= dq_req.wdata[7:0];
        end
    end

    // Map regions must not overlap
    a_one_select: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        dq_valid |-> $onehot0({sel_ram, sel_key, sel_con, sel_irq}));

endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/100ps

module scratch_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         ram_en,
    input  logic                         ram_we,
    input  logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    input  logic [31:0]                  ram_wdata,
    output logic [31:0]                  ram_rdata
);

    // Window ends below the key register at 0x1000
    if (RAM_WORDS > 4096) begin : g_size_check
        $error("scratch_ram: RAM_WORDS above 4096 overlaps the register map");
    end

    logic [31:0] mem [RAM_WORDS];

    // ==============================
    // Single port, read registered
    // ==============================
    always_ff @(posedge CLOCK_50) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                // Output keeps last read across writes
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

// ==== logic/key_irq_port.sv ====
`timescale 1ns/100ps

module key_irq_port
    import soc_bus_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      KEY0,
    // Decoded key strobe
    input  logic      key_valid,
    input  logic [7:0] key_scan,
    input  logic [7:0] key_ascii,
    // Bus side
    input  logic      key_rd,
    output key_word_u key_data,
    output logic      irq_pending,
    // Interrupt to host
    output logic      irq,
    input  logic      irq_ack
);

    key_word_u key_q;

    // ==============================
    // Key status register
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q.raw <= '0;
        end else if (key_valid) begin
            // New key beats a read in the same cycle
            key_q.fields.pressed <= 1'b1;
            key_q.fields.scan    <= key_scan;
            key_q.fields.ascii   <= key_ascii;
        end else if (key_rd) begin
            key_q.fields.pressed <= 1'b0;
        end
    end

    assign key_data = key_q;

    // ==============================
    // Interrupt line
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq <= 1'b0;
        end else if (irq_ack) begin
            // Ack has priority over a new key
            irq <= 1'b0;
        end else if (key_valid && key_ascii != 8'd0) begin
            // Only printable keys interrupt
            irq <= 1'b1;
        end
    end

    // Polled copy for IRQ_ADDR reads
    assign irq_pending = irq;

endmodule

// ==== logic/bus_response_queue.sv ====
`timescale 1ns/100ps

module bus_response_queue
    import soc_bus_pkg::*;
#(
    parameter int RSP_DEPTH    = 4,
    parameter int HOST_CREDITS = 2
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    // From decoder, valid/ready
    input  logic     rs_valid,
    output logic     rs_ready,
    input  bus_rsp_t rs_rsp,
    // To host, credit based
    output logic     rsp_valid,
    output bus_rsp_t rsp,
    input  logic     rsp_credit
);

    localparam int AW = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CW = $clog2(RSP_DEPTH + 1);
    localparam int KW = $clog2(HOST_CREDITS + 1);

    bus_rsp_t      mem [RSP_DEPTH];
    logic [AW-1:0] head;
    logic [AW-1:0] tail;
    logic [CW-1:0] count;
    logic [KW-1:0] credits;
    logic          push;

    // Room left, independent of a same-cycle pop
    assign rs_ready = (count != CW'(RSP_DEPTH));
    assign push     = rs_valid && rs_ready;

    // Send only with an entry and a host credit
    assign rsp_valid = (count != '0) && (credits != '0);
    assign rsp       = mem[head];

    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            mem[tail] <= rs_rsp;
        end
    end

    // ==============================
    // Pointers and credit counter
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            credits <= KW'(HOST_CREDITS);
        end else begin
            if (push) begin
                tail <= (tail == AW'(RSP_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (rsp_valid) begin
                head <= (head == AW'(RSP_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count   <= count + CW'(push) - CW'(rsp_valid);
            // Spend on send, refill on host return
            credits <= credits - KW'(rsp_valid) + KW'(rsp_credit);
        end
    end

    // Host returning more than it granted
    a_credit_max: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        credits <= KW'(HOST_CREDITS));

endmodule

// ==== logic/soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top
    import soc_bus_pkg::*;
#(
    parameter int REQ_DEPTH    = 4,
    parameter int RSP_DEPTH    = 4,
    parameter int HOST_CREDITS = 2,
    parameter int RAM_WORDS    = 1024
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    // Request channel
    input  logic       req_valid,
    input  bus_req_t   req,
    output logic       req_credit,
    // Response channel
    output logic       rsp_valid,
    output bus_rsp_t   rsp,
    input  logic       rsp_credit,
    // Keyboard and interrupt
    input  logic       key_valid,
    input  logic [7:0] key_scan,
    input  logic [7:0] key_ascii,
    output logic       irq,
    input  logic       irq_ack,
    // Console
    output logic       console_valid,
    output logic [7:0] console_byte
);

    localparam int RA = $clog2(RAM_WORDS);

    // ==============================
    // Internal links
    // ==============================
    // Queue to decoder
    logic          dq_valid;
    logic          dq_ready;
    bus_req_t      dq_req;
    // Decoder to response queue
    logic          rs_valid;
    logic          rs_ready;
    bus_rsp_t      rs_rsp;
    // RAM port
    logic          ram_en;
    logic          ram_we;
    logic [RA-1:0] ram_addr;
    logic [31:0]   ram_wdata;
    logic [31:0]   ram_rdata;
    // Key port
    logic          key_rd;
    key_word_u     key_data;
    logic          irq_pending;

    bus_request_queue #(.REQ_DEPTH(REQ_DEPTH)) i_req_q (
        .CLOCK_50, .KEY0,
        .req_valid, .req, .req_credit,
        .dq_valid, .dq_ready, .dq_req
    );

    bus_decoder #(.RAM_WORDS(RAM_WORDS)) i_dec (
        .CLOCK_50, .KEY0,
        .dq_valid, .dq_ready, .dq_req,
        .rs_valid, .rs_ready, .rs_rsp,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata,
        .key_rd, .key_data, .irq_pending,
        .console_valid, .console_byte
    );

    scratch_ram #(.RAM_WORDS(RAM_WORDS)) i_ram (
        .CLOCK_50,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    key_irq_port i_key (
        .CLOCK_50, .KEY0,
        .key_valid, .key_scan, .key_ascii,
        .key_rd, .key_data, .irq_pending,
        .irq, .irq_ack
    );

    bus_response_queue #(.RSP_DEPTH(RSP_DEPTH), .HOST_CREDITS(HOST_CREDITS)) i_rsp_q (
        .CLOCK_50, .KEY0,
        .rs_valid, .rs_ready, .rs_rsp,
        .rsp_valid, .rsp, .rsp_credit
    );

endmodule

// ==== tests/tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus
    import soc_bus_pkg::*;
();

    localparam int REQ_DEPTH    = 4;
    localparam int HOST_CREDITS = 2;

    // DUT ports
    logic       CLOCK_50;
    logic       KEY0;
    logic       req_valid;
    bus_req_t   req;
    logic       req_credit;
    logic       rsp_valid;
    bus_rsp_t   rsp;
    logic       rsp_credit;
    logic       key_valid;
    logic [7:0] key_scan;
    logic [7:0] key_ascii;
    logic       irq;
    logic       irq_ack;
    logic       console_valid;
    logic [7:0] console_byte;

    // Host model state
    bus_rsp_t    exp_mem [int];
    logic [31:0] ref_mem [1024];
    logic [9:0]  used_addr [$];
    key_word_u   key_ref;
    logic [31:0] rng_state;
    int          n_issued;
    int          credits_spent;
    int          cred_returned;
    int          rsp_total;
    int          con_count;
    logic [7:0]  con_last;
    logic        hold_credit;
    logic        rand_credit;

    soc_bus_top i_dut (
        .CLOCK_50, .KEY0,
        .req_valid, .req, .req_credit,
        .rsp_valid, .rsp, .rsp_credit,
        .key_valid, .key_scan, .key_ascii, .irq, .irq_ack,
        .console_valid, .console_byte
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Credits the host still holds for the request queue
    function automatic int host_credits();
        return REQ_DEPTH - credits_spent + cred_returned;
    endfunction

    function automatic bus_rsp_t make_rsp(input logic wr, input logic err,
                                          input logic [31:0] data);
        bus_rsp_t r;
        r.wr_ack  = wr;
        r.dec_err = err;
        r.rdata   = data;
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // One request, only with a credit in hand
    task automatic send_req(input logic wr, input logic [14:0] addr,
                            input logic [31:0] data, input bus_rsp_t expected);
        while (host_credits() == 0) begin
            @(posedge CLOCK_50);
            #1;
        end
        exp_mem[n_issued] = expected;
        n_issued      = n_issued + 1;
        credits_spent = credits_spent + 1;
        req_valid     = 1'b1;
        req.write     = wr;
        req.addr      = addr;
        req.wdata     = data;
        @(posedge CLOCK_50);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic write_ram(input logic [9:0] a, input logic [31:0] d);
        ref_mem[a] = d;
        send_req(1'b1, {5'd0, a}, d, make_rsp(1'b1, 1'b0, 32'd0));
    endtask

    task automatic read_ram(input logic [9:0] a);
        send_req(1'b0, {5'd0, a}, 32'd0, make_rsp(1'b0, 1'b0, ref_mem[a]))
        ;
    endtask

    // Reading the key register clears pressed
    task automatic read_key();
        send_req(1'b0, KEY_ADDR, 32'd0, make_rsp(1'b0, 1'b0, key_ref.raw));
        key_ref.fields.pressed = 1'b0;
    endtask

    task automatic wait_idle();
        while (rsp_total != n_issued) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    task automatic pulse_key(input logic [7:0] scan, input logic [7:0] ascii, input logic ack);
        key_valid = 1'b1;
        key_scan  = scan;
        key_ascii = ascii;
        irq_ack   = ack;
        @(posedge CLOCK_50);
        #1;
        key_valid = 1'b0;
        irq_ack   = 1'b0;
        key_ref.fields.pressed = 1'b1;
        key_ref.fields.scan    = scan;
        key_ref.fields.ascii   = ascii;
    endtask

    task automatic pulse_ack();
        irq_ack = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_ack = 1'b0;
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic reset_state();
        check_value("req_credit", 64'(req_credit), 64'(0));
        check_value("rsp_valid", 64'(rsp_valid), 64'(0));
        check_value("console_valid", 64'(console_valid), 64'(0));
        check_value("irq", 64'(irq), 64'(0));
    endtask

    task automatic ram_write_read();
        logic [9:0] a;
        for (int i = 0; i < 32; i++) begin
            rng_state = xorshift(rng_state);
            a = rng_state[9:0];
            rng_state = xorshift(rng_state);
            used_addr.push_back(a);
            write_ram(a, rng_state);
        end
        for (int i = 0; i < 32; i++) begin
            read_ram(used_addr[i]);
        end
        wait_idle();
    endtask

    // Back-to-back RAM and key reads, random credit return
    task automatic burst_order();
        rand_credit = 1'b1;
        for (int i = 0; i < 16; i++) begin
            if (i % 3 == 1) begin
                read_key();
            end else begin
                read_ram(used_addr[i]);
            end
        end
        wait_idle();
        repeat (8) @(posedge CLOCK_50);
        #1;
        check_value("host_credits", 64'(host_credits()), 64'(REQ_DEPTH));
        rand_credit = 1'b0;
    endtask

    task automatic credit_backpressure();
        int base;
        base = rsp_total;
        hold_credit = 1'b1;
        // Ten fit in flight: two sent, four queued, one held, three waiting
        for (int i = 0; i < 10; i++) begin
            read_ram(used_addr[31 - i]);
        end
        repeat (50) @(posedge CLOCK_50);
        #1;
        check_value("responses while stalled", 64'(rsp_total - base), 64'(HOST_CREDITS));
        hold_credit = 1'b0;
        wait_idle();
    endtask

    task automatic key_interrupt();
        pulse_key(8'h1C, 8'h61, 1'b0);
        check_value("irq", 64'(irq), 64'(1));
        send_req(1'b0, IRQ_ADDR, 32'd0, make_rsp(1'b0, 1'b0, 32'd1));
        read_key();
        read_key();
        wait_idle();
        pulse_ack();
        check_value("irq", 64'(irq), 64'(0));
        // Zero ascii latches the code but no interrupt
        pulse_key(8'h12, 8'h00, 1'b0);
        check_value("irq", 64'(irq), 64'(0));
        read_key();
        wait_idle();
        // Ack in the strobe cycle wins
        pulse_key(8'h2A, 8'h7A, 1'b1);
        check_value("irq", 64'(irq), 64'(0));
        send_req(1'b0, IRQ_ADDR, 32'd0, make_rsp(1'b0, 1'b0, 32'd0));
        read_key();
        wait_idle();
    endtask

    task automatic console_unmapped();
        int con_base;
        con_base = con_count;
        send_req(1'b1, CONSOLE_ADDR, 32'h1234_5641, make_rsp(1'b1, 1'b0, 32'd0));
        wait_idle();
        check_value("console_valid pulses", 64'(con_count - con_base), 64'(1));
        check_value("console_byte", 64'(con_last), 64'(8'h41));
        send_req(1'b0, 15'h7ABC, 32'd0, make_rsp(1'b0, 1'b1, DECODE_ERR_DATA));
        // 0x400 above a RAM word would alias it if only low bits were decoded
        send_req(1'b1, {5'b00001, used_addr[0]}, 32'hCAFE_0001, make_rsp(1'b1, 1'b1, 32'd0));
        send_req(1'b1, 15'h1003, 32'h5555_AAAA, make_rsp(1'b1, 1'b1, 32'd0));
        read_ram(used_addr[0]);
        wait_idle();
    endtask

    // ==============================
    // Response monitor
    // ==============================
    initial begin : monitor
        bus_rsp_t e;
        rsp_total     = 0;
        cred_returned = 0;
        con_count     = 0;
        con_last      = 8'h00;
        forever begin
            @(posedge CLOCK_50);
            if (KEY0) begin
                if (req_credit) begin
                    cred_returned = cred_returned + 1;
                    if (host_credits() > REQ_DEPTH) begin
                        abort_run("Request credits returned beyond the queue depth");
                    end
                end
                if (rsp_valid) begin
                    if (rsp_total >= n_issued) begin
                        abort_run("A response arrived with no request outstanding");
                    end
                    e = exp_mem[rsp_total];
                    check_value("rsp.wr_ack", 64'(rsp.wr_ack), 64'(e.wr_ack));
                    check_value("rsp.dec_err", 64'(rsp.dec_err), 64'(e.dec_err));
                    check_value("rsp.rdata", 64'(rsp.rdata), 64'(e.rdata));
                    rsp_total = rsp_total + 1;
                end
                if (console_valid) begin
                    con_count = con_count + 1;
                    con_last  = console_byte;
                end
            end
        end
    end

    // Response credit return, one pulse per consumed response
    initial begin : credit_return
        int          ret_q [$];
        int          ret_cycle;
        int          delay;
        logic [31:0] delay_state;
        rsp_credit  = 1'b0;
        ret_cycle   = 0;
        delay_state = 32'h3165;
        forever begin
            @(posedge CLOCK_50);
            ret_cycle = ret_cycle + 1;
            if (KEY0 && rsp_valid) begin
                delay = 1;
                if (rand_credit) begin
                    delay_state = xorshift(delay_state);
                    delay = 1 + int'(delay_state[1:0]);
                end
                ret_q.push_back(ret_cycle + delay);
            end
            #1;
            rsp_credit = 1'b0;
            if (!hold_credit && ret_q.size() != 0 && ret_q[0] <= ret_cycle) begin
                void'(ret_q.pop_front());
                rsp_credit = 1'b1;
            end
        end
    end

    // Watchdog, budget grows with each request
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge CLOCK_50);
            cycles = cycles + 1;
            if (cycles > 20 * n_issued + 200) begin
                abort_run($sformatf("Timed out after %0d cycles waiting for the DUT", cycles));
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin : main
        KEY0          = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        key_valid     = 1'b0;
        key_scan      = 8'h00;
        key_ascii     = 8'h00;
        irq_ack       = 1'b0;
        hold_credit   = 1'b0;
        rand_credit   = 1'b0;
        n_issued      = 0;
        credits_spent = 0;
        rng_state     = 32'h3165;
        key_ref.raw   = '0;
        repeat (2) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        reset_state();
        ram_write_read();
        burst_order();
        credit_backpressure();
        key_interrupt();
        console_unmapped();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/soc_bus_pkg.sv
logic/bus_request_queue.sv
logic/bus_decoder.sv
logic/scratch_ram.sv
logic/key_irq_port.sv
logic/bus_response_queue.sv
logic/soc_bus_top.sv
tests/tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bus subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc_bus -f sim.f -o tb_soc_bus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_bus
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
